//--- source/alpha_pkg.sv
package alpha_pkg;

	// --------------------
	// data units
	// --------------------
	typedef logic [15:0] word_t; // one sample word from the asic
	typedef logic [3:0] nybble_t; // one pmod data unit

	localparam int NYBBLES_PER_WORD = 4;

	// same word seen two ways
	// raw for readout and fifo, nybbles for the pmod side
	typedef union packed {
		word_t raw;
		nybble_t [NYBBLES_PER_WORD-1:0] nybbles; // [3] is most significant, sent first
	} alpha_word_u;

	// --------------------
	// frame markers
	// --------------------
	localparam word_t FRAME_HEADER = 16'ha1fa; // "alfa"
	localparam word_t FRAME_FOOTER = 16'h0e6a; // "omga"

	// --------------------
	// default sizes
	// --------------------
	localparam int DEFAULT_DEBOUNCE_CYCLES = 1_000_000; // 10 ms at 100 MHz, fits in 20 bits
	localparam int DEFAULT_TRIGGER_CYCLES = 16; // trigger pulse length
	localparam int DEFAULT_DRESET_CYCLES = 200; // digital reset pulse length
	localparam int DEFAULT_LOG2_FIFO_DEPTH = 10; // 1024 words

endpackage

//--- source/button_debounce.sv
`timescale 1ns/1ps

module button_debounce #(
	parameter int DEBOUNCE_CYCLES = alpha_pkg::DEFAULT_DEBOUNCE_CYCLES
) (
	input logic clock,
	input logic reset,
	input logic button, // raw, asynchronous, bouncy
	output logic press // one cycle per accepted press
);

	localparam int COUNT_WIDTH = $clog2(DEBOUNCE_CYCLES + 1);
	localparam logic [COUNT_WIDTH-1:0] LAST_COUNT = COUNT_WIDTH'(DEBOUNCE_CYCLES - 1);

	logic sync_first; // metastability stage
	logic sync_second; // safe to use
	logic armed; // button has been seen released since last press
	logic [COUNT_WIDTH-1:0] stable_count; // cycles steady at 1

	// two-flop synchronizer
	always_ff @(posedge clock) begin
		if (reset) begin
			sync_first <= 1'b0;
			sync_second <= 1'b0;
		end else begin
			sync_first <= button;
			sync_second <= sync_first;
		end
	end

	// stability counter, restarts on every bounce to 0
	always_ff @(posedge clock) begin
		if (reset) begin
			armed <= 1'b0; // a button held through reset gives no press
			stable_count <= '0;
			press <= 1'b0;
		end else begin
			press <= 1'b0;
			if (!sync_second) begin
				armed <= 1'b1; // released, next rising level counts
				stable_count <= '0;
			end else if (armed) begin
				if (stable_count == LAST_COUNT) begin
					press <= 1'b1;
					armed <= 1'b0; // held button stays quiet
				end else begin
					stable_count <= stable_count + 1'b1;
				end
			end
		end
	end

	// a single press never stretches
	assert property (@(posedge clock) disable iff (reset) press |=> !press);

endmodule

//--- source/alpha_control.sv
`timescale 1ns/1ps

module alpha_control #(
	parameter int TRIGGER_CYCLES = alpha_pkg::DEFAULT_TRIGGER_CYCLES,
	parameter int DRESET_CYCLES = alpha_pkg::DEFAULT_DRESET_CYCLES
) (
	input logic clock,
	input logic reset,
	input logic trigger_press, // debounced strobe
	input logic dreset_press, // debounced strobe
	input logic sw_bottom, // enables the bottom trigger
	output logic trig_top,
	output logic trig_bot,
	output logic dreset
);

	// --------------------
	// pulse stretchers
	// --------------------
	localparam int PULSE_MAX = (TRIGGER_CYCLES > DRESET_CYCLES) ? TRIGGER_CYCLES : DRESET_CYCLES;
	localparam int PULSE_WIDTH = $clog2(PULSE_MAX + 1);
	localparam int TRIGGER = 0; // channel index
	localparam int DRESET = 1; // channel index

	// per-channel pulse length
	localparam logic [1:0][PULSE_WIDTH-1:0] PULSE_LENGTH = {
		PULSE_WIDTH'(DRESET_CYCLES),
		PULSE_WIDTH'(TRIGGER_CYCLES)
	};

	logic [1:0] press_request;
	logic [1:0][PULSE_WIDTH-1:0] remaining; // cycles left in each pulse
	logic [1:0] pulse_active;

	assign press_request = {dreset_press, trigger_press};

	// down-counters, a press during its own pulse is ignored
	always_ff @(posedge clock) begin
		for (int i = 0; i < 2; i++) begin
			if (reset) begin
				remaining[i] <= '0;
			end else if (pulse_active[i]) begin
				remaining[i] <= remaining[i] - 1'b1;
			end else if (press_request[i]) begin
				remaining[i] <= PULSE_LENGTH[i]; // high from next clock on
			end
		end
	end

	assign pulse_active[TRIGGER] = (remaining[TRIGGER] != '0);
	assign pulse_active[DRESET] = (remaining[DRESET] != '0);

	// --------------------
	// trigger routing
	// --------------------
	assign trig_top = pulse_active[TRIGGER];
	assign trig_bot = trig_top & sw_bottom; // bottom only when switched in
	assign dreset = pulse_active[DRESET];

	// bottom trigger is a gated copy of the top one
	assert property (@(posedge clock) disable iff (reset) trig_bot |-> trig_top);

endmodule

//--- source/alpha_readout.sv
`timescale 1ns/1ps

module alpha_readout (
	input logic clock,
	input logic reset,
	input logic data_a, // serial data from the asic, msb first
	output alpha_pkg::word_t sample_word,
	output logic sample_strobe // one cycle per sample word
);

	localparam int WORD_BITS = $bits(alpha_pkg::word_t);
	localparam int COUNT_WIDTH = $clog2(WORD_BITS); // wraps once per word

	alpha_pkg::word_t shift_word; // last 16 bits seen
	logic in_frame; // 0 = hunting for header
	logic [COUNT_WIDTH-1:0] bit_count; // bits of current word in shift_word
	logic header_seen;
	logic word_complete;
	logic footer_seen;

	// --------------------
	// serial capture
	// --------------------
	always_ff @(posedge clock) begin
		shift_word <= {shift_word[WORD_BITS-2:0], data_a}; // every clock, no stall
	end

	// header can sit at any bit offset
	assign header_seen = !in_frame && (shift_word == alpha_pkg::FRAME_HEADER);
	// inside a frame only word boundaries matter
	assign word_complete = in_frame && (bit_count == '0);
	assign footer_seen = word_complete && (shift_word == alpha_pkg::FRAME_FOOTER);

	// --------------------
	// framing state
	// --------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			in_frame <= 1'b0; // hunting
			bit_count <= '0;
		end else begin
			if (header_seen) begin
				in_frame <= 1'b1;
				bit_count <= COUNT_WIDTH'(1); // first bit of word 1 lands this edge
			end else if (in_frame) begin
				bit_count <= bit_count + 1'b1; // 15 -> 0 marks a full word
				if (footer_seen) begin
					in_frame <= 1'b0; // back to hunting
				end
			end
		end
	end

	// --------------------
	// word output
	// --------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			sample_strobe <= 1'b0;
		end else begin
			sample_strobe <= word_complete && !footer_seen; // footer itself is not data
		end
	end

	// payload, qualified by sample_strobe
	always_ff @(posedge clock) begin
		if (word_complete) begin
			sample_word <= shift_word;
		end
	end

endmodule

//--- source/word_fifo.sv
`timescale 1ns/1ps

module word_fifo #(
	parameter int LOG2_FIFO_DEPTH = alpha_pkg::DEFAULT_LOG2_FIFO_DEPTH // 1 or more
) (
	input logic clock,
	input logic reset,
	input alpha_pkg::word_t write_word,
	input logic write_strobe, // no back-pressure upstream
	output alpha_pkg::word_t fifo_word, // head of queue, valid when not empty
	output logic fifo_empty,
	input logic fifo_pop,
	output logic overflow // sticky until reset
);

	localparam int DEPTH = 2 ** LOG2_FIFO_DEPTH;

	alpha_pkg::word_t storage [DEPTH];
	logic [LOG2_FIFO_DEPTH-1:0] write_pointer;
	logic [LOG2_FIFO_DEPTH-1:0] read_pointer;
	logic [LOG2_FIFO_DEPTH:0] occupancy; // 0 .. DEPTH
	logic fifo_full;
	logic write_accept;
	logic read_accept;

	assign fifo_full = (occupancy == (LOG2_FIFO_DEPTH + 1)'(DEPTH));
	assign fifo_empty = (occupancy == '0);
	assign write_accept = write_strobe && !fifo_full; // full means the word is lost
	assign read_accept = fifo_pop && !fifo_empty;
	assign fifo_word = storage[read_pointer]; // show-ahead

	// --------------------
	// pointers and count
	// --------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			write_pointer <= '0;
			read_pointer <= '0;
			occupancy <= '0;
			overflow <= 1'b0;
		end else begin
			if (write_accept) write_pointer <= write_pointer + 1'b1; // wraps at DEPTH
			if (read_accept) read_pointer <= read_pointer + 1'b1;
			case ({write_accept, read_accept})
				2'b10: occupancy <= occupancy + 1'b1;
				2'b01: occupancy <= occupancy - 1'b1;
				default: occupancy <= occupancy; // both or neither
			endcase
			if (write_strobe && fifo_full) overflow <= 1'b1;
		end
	end

	// word storage
	always_ff @(posedge clock) begin
		if (write_accept) begin
			storage[write_pointer] <= write_word;
		end
	end

	// reader must respect empty
	assert property (@(posedge clock) disable iff (reset) fifo_pop |-> !fifo_empty);

endmodule

//--- source/nybble_handshake.sv
`timescale 1ns/1ps

module nybble_handshake (
	input logic clock,
	input logic reset,
	input alpha_pkg::word_t fifo_word,
	input logic fifo_empty,
	output logic fifo_pop, // one cycle, takes the head word
	input logic acknowledge, // from the pmod receiver
	output alpha_pkg::nybble_t pmod_nybble,
	output logic pmod_first, // most significant nybble of a word
	output logic pmod_strobe
);

	localparam int INDEX_WIDTH = $clog2(alpha_pkg::NYBBLES_PER_WORD);
	localparam logic [INDEX_WIDTH-1:0] FIRST_INDEX = INDEX_WIDTH'(alpha_pkg::NYBBLES_PER_WORD - 1);

	// --------------------
	// handshake FSM states
	// --------------------
	localparam logic [1:0] ST_IDLE = 2'd0; // strobe low, waiting for a word
	localparam logic [1:0] ST_STROBE = 2'd1; // strobe high, waiting for ack high
	localparam logic [1:0] ST_RELEASE = 2'd2; // strobe low, waiting for ack low

	alpha_pkg::alpha_word_u held_word; // holding register
	logic held_valid;
	logic [INDEX_WIDTH-1:0] nybble_index; // counts down, msn first
	logic [1:0] state;

	assign fifo_pop = !held_valid && !fifo_empty; // refill as soon as the register frees
	assign pmod_nybble = held_word.nybbles[nybble_index];
	assign pmod_first = (nybble_index == FIRST_INDEX);
	assign pmod_strobe = (state == ST_STROBE);

	always_ff @(posedge clock) begin
		if (reset) begin
			held_valid <= 1'b0;
			nybble_index <= FIRST_INDEX;
			state <= ST_IDLE;
		end else begin
			if (fifo_pop) held_valid <= 1'b1;
			case (state)
				ST_IDLE: if (held_valid && !acknowledge) state <= ST_STROBE;
				ST_STROBE: if (acknowledge) state <= ST_RELEASE; // receiver has the nybble
				ST_RELEASE: begin
					if (!acknowledge) begin
						if (nybble_index == '0) begin
							held_valid <= 1'b0; // word done, free the register
							nybble_index <= FIRST_INDEX;
							state <= ST_IDLE;
						end else begin
							nybble_index <= nybble_index - 1'b1; // next nybble with new strobe
							state <= ST_STROBE;
						end
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// payload only loads into a free register
	always_ff @(posedge clock) begin
		if (fifo_pop) held_word.raw <= fifo_word;
	end

	// receiver sees one value per strobe
	assert property (@(posedge clock) disable iff (reset)
		pmod_strobe |=> !pmod_strobe || $stable(pmod_nybble));

endmodule

//--- source/alpha_tester_top.sv
`timescale 1ns/1ps

module alpha_tester_top #(
	parameter int DEBOUNCE_CYCLES = alpha_pkg::DEFAULT_DEBOUNCE_CYCLES,
	parameter int TRIGGER_CYCLES = alpha_pkg::DEFAULT_TRIGGER_CYCLES,
	parameter int DRESET_CYCLES = alpha_pkg::DEFAULT_DRESET_CYCLES,
	parameter int LOG2_FIFO_DEPTH = alpha_pkg::DEFAULT_LOG2_FIFO_DEPTH
) (
	input logic clock,
	input logic reset,
	input logic btn_trigger,
	input logic btn_dreset,
	input logic sw_bottom,
	input logic data_a,
	input logic acknowledge,
	output logic trig_top,
	output logic trig_bot,
	output logic dreset,
	output alpha_pkg::nybble_t pmod_nybble,
	output logic pmod_first,
	output logic pmod_strobe,
	output logic overflow
);

	logic trigger_press;
	logic dreset_press;
	alpha_pkg::word_t sample_word;
	logic sample_strobe;
	alpha_pkg::word_t fifo_word;
	logic fifo_empty;
	logic fifo_pop;

	// --------------------
	// buttons and pulses
	// --------------------
	button_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) trigger_debounce (
		.clock(clock), .reset(reset), .button(btn_trigger), .press(trigger_press));

	button_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) dreset_debounce (
		.clock(clock), .reset(reset), .button(btn_dreset), .press(dreset_press));

	alpha_control #(.TRIGGER_CYCLES(TRIGGER_CYCLES), .DRESET_CYCLES(DRESET_CYCLES)) alpha_control (
		.clock(clock), .reset(reset),
		.trigger_press(trigger_press), .dreset_press(dreset_press), .sw_bottom(sw_bottom),
		.trig_top(trig_top), .trig_bot(trig_bot), .dreset(dreset));

	// --------------------
	// readout path
	// --------------------
	alpha_readout alpha_readout (
		.clock(clock), .reset(reset), .data_a(data_a),
		.sample_word(sample_word), .sample_strobe(sample_strobe));

	word_fifo #(.LOG2_FIFO_DEPTH(LOG2_FIFO_DEPTH)) word_fifo (
		.clock(clock), .reset(reset),
		.write_word(sample_word), .write_strobe(sample_strobe),
		.fifo_word(fifo_word), .fifo_empty(fifo_empty), .fifo_pop(fifo_pop),
		.overflow(overflow));

	nybble_handshake nybble_handshake (
		.clock(clock), .reset(reset),
		.fifo_word(fifo_word), .fifo_empty(fifo_empty), .fifo_pop(fifo_pop),
		.acknowledge(acknowledge),
		.pmod_nybble(pmod_nybble), .pmod_first(pmod_first), .pmod_strobe(pmod_strobe));

endmodule

//--- verif/alpha_tester_checks.svh
`ifndef ALPHA_TESTER_CHECKS_SVH
`define ALPHA_TESTER_CHECKS_SVH

	// --------------------
	// compare tasks
	// --------------------
	task automatic check_word(input string name, input alpha_pkg::word_t got,
		input alpha_pkg::word_t expected);
		if (got !== expected)
			abort_run($sformatf("FAIL t=%0t %s got %h expected %h", $time, name, got, expected));
	endtask

	task automatic check_nybble(input string name, input alpha_pkg::nybble_t got,
		input alpha_pkg::nybble_t expected);
		if (got !== expected)
			abort_run($sformatf("FAIL t=%0t %s got %h expected %h", $time, name, got, expected));
	endtask

	task automatic check_bit(input string name, input logic got, input logic expected);
		if (got !== expected)
			abort_run($sformatf("FAIL t=%0t %s got %b expected %b", $time, name, got, expected));
	endtask

	// pulse lengths in cycles
	task automatic check_count(input string name, input int got, input int expected);
		if (got != expected)
			abort_run($sformatf("FAIL t=%0t %s got %0d expected %0d", $time, name, got, expected));
	endtask

	// --------------------
	// waits
	// --------------------
	// samples on falling edges, where outputs are settled
	task automatic wait_level(input logic [1:0] sel, input logic level, input string what);
		int cycles;
		cycles = 0;
		@(negedge clock);
		while (observe(sel) !== level) begin
			if (cycles == WAIT_LIMIT) abort_run($sformatf("timed out waiting for %s", what));
			cycles++;
			@(negedge clock);
		end
	endtask

`endif

//--- verif/alpha_tester_tb.sv
`timescale 1ns/1ps

module alpha_tester_tb;

	// --------------------
	// sizes and table
	// --------------------
	localparam int DEBOUNCE_CYCLES = 8;
	localparam int TRIGGER_CYCLES = 6;
	localparam int DRESET_CYCLES = 11;
	localparam int LOG2_FIFO_DEPTH = 2;
	localparam int FIFO_DEPTH = 2 ** LOG2_FIFO_DEPTH;
	localparam int WAIT_LIMIT = 400; // cycles before any wait gives up

	localparam logic [1:0] OP_FRAME = 2'd0; // also selects pmod_strobe in observe()
	localparam logic [1:0] OP_TRIGGER = 2'd1;
	localparam logic [1:0] OP_DRESET = 2'd2;

	typedef struct packed {
		logic [1:0] op;
		logic [7:0] words;
		logic sw;
		logic [3:0] ack_delay; // cycles before each acknowledge
		logic overflow; // expected, set also means acknowledge withheld
	} row_t;

	localparam row_t STIMULUS [7] = '{
		'{OP_FRAME, 8'd5, 1'b0, 4'd0, 1'b0},
		'{OP_TRIGGER, 8'd0, 1'b1, 4'd0, 1'b0}, // bottom follows top
		'{OP_FRAME, 8'd3, 1'b1, 4'd3, 1'b0}, // slow receiver
		'{OP_TRIGGER, 8'd0, 1'b0, 4'd0, 1'b0}, // bottom gated off
		'{OP_DRESET, 8'd0, 1'b0, 4'd0, 1'b0},
		'{OP_FRAME, 8'd1, 1'b0, 4'd1, 1'b0},
		'{OP_FRAME, 8'(FIFO_DEPTH + 3), 1'b0, 4'd0, 1'b1} // must overflow, so last
	};

	logic clock;
	logic reset;
	logic btn_trigger;
	logic btn_dreset;
	logic sw_bottom;
	logic data_a;
	logic acknowledge;
	logic trig_top;
	logic trig_bot;
	logic dreset;
	alpha_pkg::nybble_t pmod_nybble;
	logic pmod_first;
	logic pmod_strobe;
	logic overflow;

	integer seed;
	alpha_pkg::word_t line_history; // last 16 bits put on data_a
	alpha_pkg::word_t frame_words[$];
	alpha_pkg::word_t expected_words[$]; // what the pmod side should deliver

	alpha_tester_top #(
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES), .TRIGGER_CYCLES(TRIGGER_CYCLES),
		.DRESET_CYCLES(DRESET_CYCLES), .LOG2_FIFO_DEPTH(LOG2_FIFO_DEPTH)
	) DUT (
		.clock(clock), .reset(reset), .btn_trigger(btn_trigger), .btn_dreset(btn_dreset),
		.sw_bottom(sw_bottom), .data_a(data_a), .acknowledge(acknowledge),
		.trig_top(trig_top), .trig_bot(trig_bot), .dreset(dreset),
		.pmod_nybble(pmod_nybble), .pmod_first(pmod_first), .pmod_strobe(pmod_strobe),
		.overflow(overflow));

	always #50 clock = ~clock; // 100 ns period

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Checks failed");
		$fatal(1, "stopped at first error");
	endtask

	function automatic logic observe(input logic [1:0] sel);
		case (sel)
			OP_TRIGGER: return trig_top;
			OP_DRESET: return dreset;
			default: return pmod_strobe;
		endcase
	endfunction

`include "alpha_tester_checks.svh"

	// --------------------
	// serial frame driver
	// --------------------
	task automatic send_bit(input logic value);
		@(negedge clock);
		data_a = value;
		line_history = {line_history[14:0], value};
	endtask

	task automatic send_word(input alpha_pkg::word_t word);
		for (int i = 15; i >= 0; i--) send_bit(word[i]); // msb first
	endtask

	// random bits, flipped where one would finish a header
	task automatic send_noise(input int bits);
		logic value;
		for (int i = 0; i < bits; i++) begin
			value = 1'($random(seed));
			if ({line_history[14:0], value} == alpha_pkg::FRAME_HEADER) value = ~value;
			send_bit(value);
		end
	endtask

	// would the header match before its own last bit
	function automatic logic header_too_early(input alpha_pkg::word_t history);
		alpha_pkg::word_t header;
		alpha_pkg::word_t window;
		header = alpha_pkg::FRAME_HEADER;
		window = history;
		for (int i = 15; i > 0; i--) begin
			window = {window[14:0], header[i]};
			if (window == header) return 1'b1;
		end
		return 1'b0;
	endfunction

	task automatic send_frame();
		int tries;
		tries = 0;
		send_noise(1 + {$random(seed)} % 16); // header at a random bit offset
		while (header_too_early(line_history)) begin
			if (tries == 32) abort_run("no clean position found for the frame header");
			send_noise(1);
			tries++;
		end
		send_word(alpha_pkg::FRAME_HEADER);
		foreach (frame_words[i]) send_word(frame_words[i]);
		send_word(alpha_pkg::FRAME_FOOTER);
		send_noise(1 + {$random(seed)} % 24); // junk after the footer
		repeat (16) send_bit(1'b1); // idle high, never completes a header
	endtask

	// --------------------
	// pmod receiver
	// --------------------
	task automatic receive_words(input int ack_delay);
		alpha_pkg::word_t word;
		alpha_pkg::word_t received;
		while (expected_words.size() > 0) begin
			word = expected_words.pop_front();
			for (int n = 3; n >= 0; n--) begin
				wait_level(OP_FRAME, 1'b1, "pmod_strobe to rise");
				check_nybble("pmod_nybble", pmod_nybble, word[4*n +: 4]);
				check_bit("pmod_first", pmod_first, n == 3); // msn only
				repeat (ack_delay) @(negedge clock);
				check_bit("pmod_strobe", pmod_strobe, 1'b1); // held until acknowledged
				received = {received[11:0], pmod_nybble}; // latched at acknowledge
				acknowledge = 1'b1;
				wait_level(OP_FRAME, 1'b0, "pmod_strobe to fall");
				acknowledge = 1'b0;
			end
			check_word("received word", received, word);
		end
	endtask

	task automatic run_frame(input int count, input int ack_delay, input logic withhold);
		alpha_pkg::word_t word;
		int keep;
		keep = withhold ? FIFO_DEPTH + 1 : count; // fifo plus holding register
		frame_words.delete();
		for (int i = 0; i < count; i++) begin
			word = 16'($random(seed));
			while (word == alpha_pkg::FRAME_FOOTER) word = 16'($random(seed));
			frame_words.push_back(word);
			if (i < keep) expected_words.push_back(word);
		end
		if (withhold) begin
			send_frame(); // acknowledge stays low all along
			check_bit("overflow", overflow, 1'b1);
			receive_words(ack_delay);
		end else begin
			fork
				send_frame();
				receive_words(ack_delay);
			join
		end
		repeat (48) begin // nothing left behind the footer
			@(negedge clock);
			check_bit("pmod_strobe", pmod_strobe, 1'b0);
		end
	endtask

	// --------------------
	// buttons and pulses
	// --------------------
	task automatic press_and_measure(input logic [1:0] op, input logic sw);
		logic level;
		int width;
		level = 1'b1;
		for (int i = 0; i < 7; i++) begin // bounce, ends high
			if (op == OP_DRESET) btn_dreset = level;
			else btn_trigger = level;
			repeat (1 + {$random(seed)} % 3) @(negedge clock); // shorter than debounce
			level = ~level;
		end
		wait_level(op, 1'b1, "the pulse to start");
		width = 0;
		while (observe(op) === 1'b1) begin
			check_bit("trig_bot", trig_bot, sw && op == OP_TRIGGER);
			width++;
			if (width > WAIT_LIMIT) abort_run("pulse never ended");
			@(negedge clock);
		end
		check_count("pulse width", width, (op == OP_DRESET) ? DRESET_CYCLES : TRIGGER_CYCLES);
		repeat (2 * DRESET_CYCLES) begin // still held, no second pulse
			check_bit("second pulse", observe(op), 1'b0);
			@(negedge clock);
		end
		btn_trigger = 1'b0;
		btn_dreset = 1'b0;
		repeat (4) @(negedge clock);
	endtask

	initial begin
		seed = 32'h98b7_6638;
		clock = 1'b0;
		reset = 1'b1;
		btn_trigger = 1'b0;
		btn_dreset = 1'b0;
		sw_bottom = 1'b0;
		data_a = 1'b1; // line idles high
		acknowledge = 1'b0;
		line_history = '1;
		repeat (5) @(negedge clock);
		reset = 1'b0;
		check_bit("trig_top", trig_top, 1'b0);
		check_bit("trig_bot", trig_bot, 1'b0);
		check_bit("dreset", dreset, 1'b0);
		check_bit("pmod_strobe", pmod_strobe, 1'b0);
		check_bit("overflow", overflow, 1'b0);
		repeat (16) send_bit(1'b1); // fill the readout shift register
		foreach (STIMULUS[r]) begin
			sw_bottom = STIMULUS[r].sw;
			case (STIMULUS[r].op)
				OP_FRAME: run_frame(STIMULUS[r].words, STIMULUS[r].ack_delay,
					STIMULUS[r].overflow);
				OP_TRIGGER: press_and_measure(OP_TRIGGER, STIMULUS[r].sw);
				OP_DRESET: press_and_measure(OP_DRESET, STIMULUS[r].sw);
				default: abort_run("unknown operation in the stimulus table");
			endcase
			check_bit("overflow", overflow, STIMULUS[r].overflow);
		end
		$display("All checks passed");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+verif
source/alpha_pkg.sv
source/button_debounce.sv
source/alpha_control.sv
source/alpha_readout.sv
source/word_fifo.sv
source/nybble_handshake.sv
source/alpha_tester_top.sv
verif/alpha_tester_tb.sv

//--- Makefile
TOP = alpha_tester_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f filelist.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Checks failed" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "All checks passed" sim.log; then echo "simulation did not finish"; exit 1; fi

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f filelist.f

clean:
	rm -rf obj_dir sim.log
